// ==== Bender.yml ====
package:
  name: ads_i2c_master

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/ads_pkg.sv
      - rtl/i2c_xfer_if.sv
      - rtl/ads_request_sched.sv
      - rtl/i2c_byte_engine.sv
      - rtl/ads_result_bank.sv
      - rtl/ads_i2c_master.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tb/ads_props.sv
      - tb/ads_slave_model.sv
      - tb/tb_ads_i2c_master.sv

// ==== list.f ====
+incdir+rtl
rtl/ads_pkg.sv
rtl/i2c_xfer_if.sv
rtl/ads_request_sched.sv
rtl/i2c_byte_engine.sv
rtl/ads_result_bank.sv
rtl/ads_i2c_master.sv
tb/ads_props.sv
tb/ads_slave_model.sv
tb/tb_ads_i2c_master.sv

// ==== rtl/ads_config.svh ====
// ADC master configuration
`ifndef ADS_CONFIG_SVH
`define ADS_CONFIG_SVH

// i2c_clk cycles per quarter of one SCL bit
`define ADS_SCL_QUARTER 2

// cycles to wait for DRDY before RDATA is sent anyway
`define ADS_DRDY_TIMEOUT 400

// device command bytes
`define ADS_CMD_WREG_CFG0 8'h40
`define ADS_CMD_START 8'h08
`define ADS_CMD_RDATA 8'h10

// mux byte for AIN0, each further channel adds 16
`define ADS_MUX_BASE 8'h81

`endif

// ==== rtl/ads_i2c_master.sv ====
// ADC I2C master top
`timescale 1ns/1ns

module ads_i2c_master import ads_pkg::*; (
	input  logic       i2c_clk,
	input  logic       i_rst_n,
	input  logic [6:0] i_dev_addr,
	input  logic       i_cpu_valid,
	output logic       o_cpu_ready,
	input  cpu_op_e    i_cpu_op,
	input  logic [7:0] i_cpu_cmd,
	input  logic [7:0] i_cpu_wdata,
	input  logic       i_scan_en,
	input  logic       i_drdy_n,
	output logic       o_rd_valid,
	output logic [7:0] o_rd_data,
	output ain_t       o_ain0,
	output ain_t       o_ain1,
	output ain_t       o_ain2,
	output ain_t       o_ain3,
	output logic       o_ain_valid,
	output logic       o_nack,
	inout  wire        i2c_scl,
	inout  wire        i2c_sda
);

	i2c_xfer_if xfer ();

	ads_request_sched u_sched (
		.i2c_clk     (i2c_clk),
		.i_rst_n     (i_rst_n),
		.i_dev_addr  (i_dev_addr),
		.i_cpu_valid (i_cpu_valid),
		.i_cpu_op    (i_cpu_op),
		.i_cpu_cmd   (i_cpu_cmd),
		.i_cpu_wdata (i_cpu_wdata),
		.i_scan_en   (i_scan_en),
		.i_drdy_n    (i_drdy_n),
		.o_cpu_ready (o_cpu_ready),
		.xfer        (xfer.sched)
	);

	i2c_byte_engine u_engine (
		.i2c_clk (i2c_clk),
		.i_rst_n (i_rst_n),
		.xfer    (xfer.engine),
		.io_scl  (i2c_scl),
		.io_sda  (i2c_sda)
	);

	ads_result_bank u_bank (
		.i2c_clk     (i2c_clk),
		.i_rst_n     (i_rst_n),
		.xfer        (xfer.bank),
		.o_ain0      (o_ain0),
		.o_ain1      (o_ain1),
		.o_ain2      (o_ain2),
		.o_ain3      (o_ain3),
		.o_ain_valid (o_ain_valid),
		.o_rd_valid  (o_rd_valid),
		.o_rd_data   (o_rd_data),
		.o_nack      (o_nack)
	);

endmodule

// ==== rtl/ads_pkg.sv ====
// ADC master types
package ads_pkg;

	typedef enum logic {
		CPU_WREG = 1'b0,
		CPU_RREG = 1'b1
	} cpu_op_e;

	// byte counts after the address byte: 1, 2, 1, 3
	typedef enum logic [1:0] {
		XFER_WR1 = 2'd0,
		XFER_WR2 = 2'd1,
		XFER_RD1 = 2'd2,
		XFER_RD3 = 2'd3
	} xfer_op_e;

	typedef enum logic [2:0] {
		SCAN_MUX   = 3'd0,
		SCAN_START = 3'd1,
		SCAN_WAIT  = 3'd2,
		SCAN_RDATA = 3'd3,
		SCAN_READ  = 3'd4
	} scan_state_e;

	typedef enum logic [2:0] {
		EN_IDLE  = 3'd0,
		EN_START = 3'd1,
		EN_BYTE  = 3'd2,
		EN_ACK   = 3'd3,
		EN_STOP  = 3'd4
	} engine_state_e;

	typedef logic [1:0] chan_t;

	typedef logic signed [31:0] ain_t;

	// where a response goes, neither bit set means discard
	typedef struct packed {
		logic  to_host; // low byte to the host read port
		logic  to_chan; // three bytes to a channel result
		chan_t chan;
	} xfer_tag_t;

endpackage

// ==== rtl/ads_request_sched.sv ====
// Host and scan request scheduler
`timescale 1ns/1ns
`include "ads_config.svh"

module ads_request_sched import ads_pkg::*; (
	input  logic       i2c_clk,
	input  logic       i_rst_n,
	input  logic [6:0] i_dev_addr,
	input  logic       i_cpu_valid,
	input  cpu_op_e    i_cpu_op,
	input  logic [7:0] i_cpu_cmd,
	input  logic [7:0] i_cpu_wdata,
	input  logic       i_scan_en,
	input  logic       i_drdy_n,
	output logic       o_cpu_ready,
	i2c_xfer_if.sched  xfer
);

	localparam int TW = $clog2(`ADS_DRDY_TIMEOUT + 1);

	scan_state_e   scan_st;
	chan_t         chan;
	logic          drdy_s1;
	logic          drdy_s2;
	logic [TW-1:0] wait_cnt;
	logic          busy; // accepted, response not yet seen
	logic          host_busy;
	logic          host_rd2; // read half of a RREG still to issue
	logic          can_issue;
	logic          sched_idle;
	logic          wait_done;
	logic          scan_go;
	xfer_op_e      scan_op;
	logic          scan_rw;
	logic [7:0]    scan_b0;
	logic [7:0]    mux_byte;
	xfer_tag_t     scan_tag;

	assign mux_byte   = `ADS_MUX_BASE + {2'b00, chan, 4'h0};
	assign can_issue  = !xfer.req_valid && !busy;
	// host only gets in between whole channel sequences
	assign sched_idle = can_issue && !host_busy && (scan_st == SCAN_MUX);
	assign o_cpu_ready = sched_idle && i_cpu_valid;
	assign wait_done  = !drdy_s2 || (wait_cnt == TW'(`ADS_DRDY_TIMEOUT - 1));

	// drdy synchronizer, idles high
	always_ff @(posedge i2c_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			drdy_s1 <= 1'b1;
			drdy_s2 <= 1'b1;
		end else begin
			drdy_s1 <= i_drdy_n;
			drdy_s2 <= drdy_s1;
		end
	end

	// request for the current scan step
	always_comb begin
		scan_go  = 1'b1;
		scan_op  = XFER_WR1;
		scan_rw  = 1'b0;
		scan_b0  = `ADS_CMD_START;
		scan_tag = '{to_host: 1'b0, to_chan: 1'b0, chan: chan};
		case (scan_st)
			SCAN_MUX: begin
				scan_go = i_scan_en && !i_cpu_valid; // pending host wins here
				scan_op = XFER_WR2;
				scan_b0 = `ADS_CMD_WREG_CFG0;
			end
			SCAN_START: scan_b0 = `ADS_CMD_START;
			SCAN_RDATA: scan_b0 = `ADS_CMD_RDATA;
			SCAN_READ: begin
				scan_op = XFER_RD3;
				scan_rw = 1'b1;
				scan_tag.to_chan = 1'b1;
			end
			default: scan_go = 1'b0; // waiting on drdy
		endcase
	end

	always_ff @(posedge i2c_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			xfer.req_valid <= 1'b0;
			busy      <= 1'b0;
			host_busy <= 1'b0;
			host_rd2  <= 1'b0;
			scan_st   <= SCAN_MUX;
			chan      <= '0;
			wait_cnt  <= '0;
		end else begin
			if (xfer.req_valid && xfer.req_ready) begin
				xfer.req_valid <= 1'b0;
				busy <= 1'b1;
			end

			if (can_issue) begin
				if (host_rd2) begin
					xfer.req_valid <= 1'b1;
					host_rd2 <= 1'b0;
				end else if (o_cpu_ready) begin
					xfer.req_valid <= 1'b1;
					host_busy <= 1'b1;
					host_rd2  <= (i_cpu_op == CPU_RREG);
				end else if (!host_busy && scan_go) begin
					xfer.req_valid <= 1'b1;
				end
			end

			if (xfer.rsp_valid) begin
				busy <= 1'b0;
				if (host_busy) begin
					if (xfer.rsp_nack || !host_rd2)
						host_busy <= 1'b0;
					if (xfer.rsp_nack)
						host_rd2 <= 1'b0; // drop the read half
				end else if (xfer.rsp_nack) begin
					scan_st <= SCAN_MUX; // same channel again
				end else begin
					case (scan_st)
						SCAN_MUX:   scan_st <= SCAN_START;
						SCAN_START: begin
							scan_st  <= SCAN_WAIT;
							wait_cnt <= '0;
						end
						SCAN_RDATA: scan_st <= SCAN_READ;
						SCAN_READ: begin
							scan_st <= SCAN_MUX;
							chan    <= chan + 1'b1; // wraps 3 -> 0
						end
						default: ;
					endcase
				end
			end

			if (scan_st == SCAN_WAIT) begin
				if (wait_done)
					scan_st <= SCAN_RDATA;
				else
					wait_cnt <= wait_cnt + 1'b1;
			end
		end
	end

	// request fields, held until the engine takes them
	always_ff @(posedge i2c_clk) begin
		if (can_issue) begin
			if (host_rd2) begin
				xfer.req_addr <= i_dev_addr;
				xfer.req_op   <= XFER_RD1;
				xfer.req_rw   <= 1'b1;
				xfer.rsp_tag  <= '{to_host: 1'b1, to_chan: 1'b0, chan: chan};
			end else if (o_cpu_ready) begin
				xfer.req_addr <= i_dev_addr;
				xfer.req_op   <= (i_cpu_op == CPU_RREG) ? XFER_WR1 : XFER_WR2;
				xfer.req_rw   <= 1'b0;
				xfer.byte0    <= i_cpu_cmd;
				xfer.byte1    <= i_cpu_wdata;
				xfer.rsp_tag  <= '{to_host: 1'b0, to_chan: 1'b0, chan: chan};
			end else if (!host_busy && scan_go) begin
				xfer.req_addr <= i_dev_addr;
				xfer.req_op   <= scan_op;
				xfer.req_rw   <= scan_rw;
				xfer.byte0    <= scan_b0;
				xfer.byte1    <= mux_byte;
				xfer.rsp_tag  <= scan_tag;
			end
		end
	end

endmodule

// ==== rtl/ads_result_bank.sv ====
// Channel results and host read data
`timescale 1ns/1ns

module ads_result_bank import ads_pkg::*; (
	input  logic       i2c_clk,
	input  logic       i_rst_n,
	i2c_xfer_if.bank   xfer,
	output ain_t       o_ain0,
	output ain_t       o_ain1,
	output ain_t       o_ain2,
	output ain_t       o_ain3,
	output logic       o_ain_valid,
	output logic       o_rd_valid,
	output logic [7:0] o_rd_data,
	output logic       o_nack
);

	logic rsp_ok;

	assign rsp_ok = xfer.rsp_valid && !xfer.rsp_nack;

	always_ff @(posedge i2c_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_ain0      <= '0;
			o_ain1      <= '0;
			o_ain2      <= '0;
			o_ain3      <= '0;
			o_ain_valid <= 1'b0;
			o_rd_valid  <= 1'b0;
			o_nack      <= 1'b0;
		end else begin
			o_ain_valid <= rsp_ok && xfer.rsp_tag.to_chan;
			o_rd_valid  <= rsp_ok && xfer.rsp_tag.to_host;
			o_nack      <= xfer.rsp_valid && xfer.rsp_nack;
			if (rsp_ok && xfer.rsp_tag.to_chan) begin
				// 24-bit conversion, zero extended
				case (xfer.rsp_tag.chan)
					2'd0: o_ain0 <= {8'h00, xfer.rsp_data};
					2'd1: o_ain1 <= {8'h00, xfer.rsp_data};
					2'd2: o_ain2 <= {8'h00, xfer.rsp_data};
					default: o_ain3 <= {8'h00, xfer.rsp_data};
				endcase
			end
		end
	end

	always_ff @(posedge i2c_clk) begin
		if (rsp_ok && xfer.rsp_tag.to_host)
			o_rd_data <= xfer.rsp_data[7:0]; // single byte lands low
	end

endmodule

// ==== rtl/i2c_byte_engine.sv ====
// Open-drain I2C byte engine
`timescale 1ns/1ns
`include "ads_config.svh"

module i2c_byte_engine import ads_pkg::*; (
	input  logic        i2c_clk,
	input  logic        i_rst_n,
	i2c_xfer_if.engine  xfer,
	inout  wire         io_scl,
	inout  wire         io_sda
);

	localparam int QW = $clog2(`ADS_SCL_QUARTER + 1);
	localparam logic [QW-1:0] Q_LAST = QW'(`ADS_SCL_QUARTER - 1);

	engine_state_e st;
	logic [QW-1:0] q_cnt; // cycles inside one quarter
	logic [1:0]    phase; // quarter inside one bit
	logic [2:0]    bit_cnt;
	logic [1:0]    byte_cnt; // data bytes left after the current one
	logic          addr_ph; // address byte on the wire
	logic          rw_q;
	logic          nack_q;
	logic [7:0]    shreg;
	logic [7:0]    b0_q;
	logic [7:0]    b1_q;
	logic          q_tick;
	logic          bit_end;
	logic          rd_byte;
	logic          sda_in;
	logic          scl_lo;
	logic          sda_lo;

	assign q_tick  = (q_cnt == Q_LAST);
	assign bit_end = q_tick && (phase == 2'd3);
	assign rd_byte = rw_q && !addr_ph; // slave drives the data bits
	assign sda_in  = io_sda;

	assign xfer.req_ready = (st == EN_IDLE);
	assign xfer.rsp_nack  = nack_q;

	// quarter timing, parked while idle
	always_ff @(posedge i2c_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			q_cnt <= '0;
			phase <= '0;
		end else if (st == EN_IDLE) begin
			q_cnt <= '0;
			phase <= '0;
		end else if (q_tick) begin
			q_cnt <= '0;
			phase <= phase + 2'd1;
		end else begin
			q_cnt <= q_cnt + 1'b1;
		end
	end

	always_ff @(posedge i2c_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			st       <= EN_IDLE;
			bit_cnt  <= '0;
			byte_cnt <= '0;
			addr_ph  <= 1'b0;
			rw_q     <= 1'b0;
			nack_q   <= 1'b0;
			xfer.rsp_valid <= 1'b0;
		end else begin
			xfer.rsp_valid <= 1'b0;
			case (st)
				EN_IDLE: begin
					if (xfer.req_valid) begin
						st      <= EN_START;
						rw_q    <= xfer.req_rw;
						addr_ph <= 1'b1;
						nack_q  <= 1'b0;
						bit_cnt <= 3'd7;
						case (xfer.req_op)
							XFER_WR2: byte_cnt <= 2'd2;
							XFER_RD3: byte_cnt <= 2'd3;
							default:  byte_cnt <= 2'd1;
						endcase
					end
				end
				EN_START: begin
					if (bit_end)
						st <= EN_BYTE;
				end
				EN_BYTE: begin
					if (bit_end) begin
						if (bit_cnt == 3'd0)
							st <= EN_ACK;
						bit_cnt <= bit_cnt - 1'b1; // 0 wraps to 7 for the next byte
					end
				end
				EN_ACK: begin
					if (q_tick && phase == 2'd2 && !rd_byte)
						nack_q <= sda_in; // released line means NACK
					if (bit_end) begin
						if (nack_q || byte_cnt == 2'd0) begin
							st <= EN_STOP;
						end else begin
							st       <= EN_BYTE;
							byte_cnt <= byte_cnt - 1'b1;
							addr_ph  <= 1'b0;
						end
					end
				end
				EN_STOP: begin
					if (bit_end) begin
						st <= EN_IDLE;
						xfer.rsp_valid <= 1'b1;
					end
				end
				default: st <= EN_IDLE;
			endcase
		end
	end

	// shift register and read data
	always_ff @(posedge i2c_clk) begin
		if (st == EN_IDLE && xfer.req_valid) begin
			shreg <= {xfer.req_addr, xfer.req_rw};
			b0_q  <= xfer.byte0;
			b1_q  <= xfer.byte1;
			xfer.rsp_data <= '0;
		end else if (st == EN_BYTE) begin
			if (rd_byte && q_tick && phase == 2'd2)
				shreg <= {shreg[6:0], sda_in}; // sample while SCL is high
			else if (!rd_byte && bit_end)
				shreg <= {shreg[6:0], 1'b0};
		end else if (st == EN_ACK && bit_end) begin
			if (rd_byte)
				xfer.rsp_data <= {xfer.rsp_data[15:0], shreg};
			shreg <= addr_ph ? b0_q : b1_q;
		end
	end

	// SCL high in quarters 1 and 2 of a bit, SDA moves only in quarter 0
	always_comb begin
		scl_lo = 1'b0;
		sda_lo = 1'b0;
		case (st)
			EN_START: begin
				scl_lo = (phase == 2'd3);
				sda_lo = phase[1]; // falls with SCL high
			end
			EN_BYTE: begin
				scl_lo = (phase == 2'd0) || (phase == 2'd3);
				sda_lo = !rd_byte && !shreg[7];
			end
			EN_ACK: begin
				scl_lo = (phase == 2'd0) || (phase == 2'd3);
				sda_lo = rd_byte && (byte_cnt != 2'd0); // last read byte gets NACK
			end
			EN_STOP: begin
				scl_lo = (phase == 2'd0);
				sda_lo = !phase[1]; // rises with SCL high
			end
			default: ;
		endcase
	end

	assign io_scl = scl_lo ? 1'b0 : 1'bz;
	assign io_sda = sda_lo ? 1'b0 : 1'bz;

endmodule

// ==== rtl/i2c_xfer_if.sv ====
// Transfer request and response channel
`timescale 1ns/1ns

interface i2c_xfer_if import ads_pkg::*; ();

	logic        req_valid;
	logic        req_ready; // only high while the engine is idle
	xfer_op_e    req_op;
	logic        req_rw; // R/W bit sent with the address
	logic [6:0]  req_addr;
	logic [7:0]  byte0;
	logic [7:0]  byte1;

	// one-cycle response, no back-pressure
	logic        rsp_valid;
	logic        rsp_nack;
	logic [23:0] rsp_data; // first byte read sits in [23:16]
	xfer_tag_t   rsp_tag;

	modport sched (
		output req_valid, req_op, req_rw, req_addr, byte0, byte1, rsp_tag,
		input  req_ready, rsp_valid, rsp_nack, rsp_data
	);

	modport engine (
		input  req_valid, req_op, req_rw, req_addr, byte0, byte1,
		output req_ready, rsp_valid, rsp_nack, rsp_data
	);

	modport bank (
		input rsp_valid, rsp_nack, rsp_data, rsp_tag
	);

endinterface

// ==== tb/ads_props.sv ====
// Bus and handshake assertions
`timescale 1ns/1ns

module ads_props import ads_pkg::*; (
	input logic          i2c_clk,
	input logic          i_rst_n,
	input logic          i_scl,
	input logic          i_sda,
	input engine_state_e i_st,
	input logic          i_req_valid,
	input logic          i_req_ready,
	input logic          i_rsp_valid
);

	// SDA may only move with SCL high at START and STOP
	a_sda_fall: assert property (@(posedge i2c_clk) disable iff (!i_rst_n)
		($past(i_scl) && i_scl && $fell(i_sda)) |-> (i_st == EN_START))
		else $error("SDA fell while SCL was high outside START");

	a_sda_rise: assert property (@(posedge i2c_clk) disable iff (!i_rst_n)
		($past(i_scl) && i_scl && $rose(i_sda)) |-> (i_st == EN_STOP))
		else $error("SDA rose while SCL was high outside STOP");

	a_req_hold: assert property (@(posedge i2c_clk) disable iff (!i_rst_n)
		(i_req_valid && !i_req_ready) |=> i_req_valid)
		else $error("request withdrawn before it was accepted");

	a_rsp_pulse: assert property (@(posedge i2c_clk) disable iff (!i_rst_n)
		i_rsp_valid |=> !i_rsp_valid)
		else $error("response valid held longer than one cycle");

	a_reset_idle: assert property (@(posedge i2c_clk)
		!i_rst_n |-> (i_scl !== 1'b0 && i_sda !== 1'b0))
		else $error("bus line pulled low during reset");

endmodule

// ==== tb/ads_slave_model.sv ====
// Behavioral ADC slave
`timescale 1ns/1ns
`include "ads_config.svh"

module ads_slave_model (
	input  logic i_clk,
	input  logic i_silent, // keep DRDY high
	output logic o_drdy_n,
	inout  wire  io_scl,
	inout  wire  io_sda
);

	localparam logic [6:0] DEV_ADDR = 7'h40;

	typedef enum {S_IDLE, S_ADDR, S_WR, S_RD, S_SKIP} slave_state_e;

	slave_state_e st = S_IDLE;
	logic [7:0]   sh;
	logic [7:0]   tx;
	logic         rw;
	logic         mack; // master acked the last read byte
	logic         sda_lo = 1'b0;
	int           cnt = 0;
	int           widx;
	int           ridx;
	int           drdy_wait = 0;
	int           stop_cnt = 0;
	logic [7:0]   last_cmd = 8'h00;
	logic [7:0]   last_mux = 8'h00;
	logic [7:0]   regs [256];
	logic [23:0]  conv_tab [4]; // loaded by the testbench
	logic [7:0]   wlog [$]; // every byte the master wrote, address bytes too

	assign io_sda = sda_lo ? 1'b0 : 1'bz;

	initial begin
		o_drdy_n = 1'b1;
		for (int i = 0; i < 256; i++)
			regs[i] = i[7:0] * 8'd7 + 8'h3c;
	end

	function automatic logic [7:0] next_byte(input int idx);
		logic [7:0]  d;
		logic [23:0] conv;
		d = last_mux - `ADS_MUX_BASE;
		conv = conv_tab[d[5:4]] ^ {last_mux, 16'h0000};
		if (last_cmd == `ADS_CMD_RDATA)
			next_byte = (idx == 0) ? conv[23:16] : (idx == 1) ? conv[15:8] : conv[7:0];
		else
			next_byte = (idx == 0) ? regs[last_cmd] : 8'hff;
	endfunction

	always @(negedge io_sda) if (io_scl === 1'b1) begin // start
		st = S_ADDR;
		cnt = 0;
		widx = 0;
		ridx = 0;
		sda_lo = 1'b0;
	end

	always @(posedge io_sda) if (io_scl === 1'b1) begin // stop
		if (st != S_IDLE)
			stop_cnt++;
		st = S_IDLE;
		sda_lo = 1'b0;
	end

	always @(posedge io_scl) if (st != S_IDLE) begin
		if (cnt < 8)
			sh = {sh[6:0], io_sda};
		else
			mack = (io_sda === 1'b0);
		cnt++;
	end

	always @(negedge io_scl) begin
		if (cnt == 8) begin
			case (st)
				S_ADDR: begin
					wlog.push_back(sh);
					rw = sh[0];
					if (sh[7:1] == DEV_ADDR)
						sda_lo = 1'b1;
					else
						st = S_SKIP; // not ours, no ack
				end
				S_WR: begin
					wlog.push_back(sh);
					if (widx == 0) begin
						last_cmd = sh;
						if (sh == `ADS_CMD_START)
							drdy_wait = 30;
						if (sh == `ADS_CMD_RDATA)
							o_drdy_n = 1'b1;
					end else if (widx == 1 && last_cmd == `ADS_CMD_WREG_CFG0) begin
						last_mux = sh;
					end
					widx++;
					sda_lo = 1'b1;
				end
				S_RD: sda_lo = 1'b0; // master drives ack
				default: ;
			endcase
		end else if (cnt == 9) begin
			cnt = 0;
			sda_lo = 1'b0;
			if (st == S_ADDR)
				st = rw ? S_RD : S_WR;
			else if (st == S_RD && !mack)
				st = S_SKIP;
			if (st == S_RD) begin
				tx = next_byte(ridx);
				ridx++;
				sda_lo = !tx[7];
			end
		end else if (st == S_RD && cnt >= 1 && cnt <= 7) begin
			sda_lo = !tx[7 - cnt];
		end
	end

	// DRDY low 30 cycles after a START command
	always @(posedge i_clk) begin
		if (drdy_wait != 0) begin
			drdy_wait <= drdy_wait - 1;
			if (drdy_wait == 1 && !i_silent)
				o_drdy_n <= 1'b0;
		end
	end

endmodule

// ==== tb/tb_ads_i2c_master.sv ====
// ADC I2C master testbench
`timescale 1ns/1ns
`include "ads_config.svh"

module tb_ads_i2c_master import ads_pkg::*; ();

	localparam int SCAN_BITS = 29 + 20 + 20 + 38; // one channel sequence
	localparam int SCAN_CHANS = 10;
	localparam int HOST_BITS = 2 * 29 + 4 * 40;
	localparam int LIMIT = ((SCAN_CHANS * (SCAN_BITS * 8 + 40) + `ADS_DRDY_TIMEOUT
		+ HOST_BITS * 8 + 8) * 5) / 4;

	logic       clk;
	logic       rst_n;
	logic [6:0] dev_addr;
	logic       cpu_valid;
	logic       cpu_ready;
	cpu_op_e    cpu_op;
	logic [7:0] cpu_cmd;
	logic [7:0] cpu_wdata;
	logic       scan_en;
	logic       drdy_n;
	logic       silent;
	logic       rd_valid;
	logic [7:0] rd_data;
	ain_t       ain0;
	ain_t       ain1;
	ain_t       ain2;
	ain_t       ain3;
	logic       ain_valid;
	logic       nack;
	wire        scl;
	wire        sda;

	int          errors = 0;
	int          checks = 0;
	int          cycles = 0;
	int          ain_cnt = 0;
	int          rd_cnt = 0;
	int          nack_cnt = 0;
	int          exp_chan = 0; // next channel expected from the scan
	int          stop_mark;
	int          wait_mark; // cycle count when the silent step began
	int          seed;
	logic [7:0]  exp_rd;
	logic        nack_ok = 1'b0;
	logic [23:0] conv_tab [4];

	pullup (scl);
	pullup (sda);

	ads_i2c_master dut0 (
		.i2c_clk(clk), .i_rst_n(rst_n), .i_dev_addr(dev_addr),
		.i_cpu_valid(cpu_valid), .o_cpu_ready(cpu_ready), .i_cpu_op(cpu_op),
		.i_cpu_cmd(cpu_cmd), .i_cpu_wdata(cpu_wdata), .i_scan_en(scan_en),
		.i_drdy_n(drdy_n), .o_rd_valid(rd_valid), .o_rd_data(rd_data),
		.o_ain0(ain0), .o_ain1(ain1), .o_ain2(ain2), .o_ain3(ain3),
		.o_ain_valid(ain_valid), .o_nack(nack), .i2c_scl(scl), .i2c_sda(sda)
	);

	ads_slave_model slave0 (
		.i_clk(clk), .i_silent(silent), .o_drdy_n(drdy_n), .io_scl(scl), .io_sda(sda)
	);

	bind i2c_byte_engine ads_props props0 (
		.i2c_clk(i2c_clk), .i_rst_n(i_rst_n), .i_scl(io_scl), .i_sda(io_sda), .i_st(st),
		.i_req_valid(xfer.req_valid), .i_req_ready(xfer.req_ready),
		.i_rsp_valid(xfer.rsp_valid)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// expected conversion, mux byte folded into the top byte
	function automatic ain_t ref_conv(input chan_t ch);
		logic [7:0] mux;
		mux = `ADS_MUX_BASE + 8'(ch) * 8'd16;
		ref_conv = {8'h00, conv_tab[ch] ^ {mux, 16'h0000}};
	endfunction

	always @(posedge clk) begin
		ain_t       got;
		logic [7:0] exp_mux;
		if (rst_n) begin
			if (ain_valid) begin
				got = (exp_chan == 0) ? ain0 : (exp_chan == 1) ? ain1 :
					(exp_chan == 2) ? ain2 : ain3;
				exp_mux = 8'(`ADS_MUX_BASE + 16 * exp_chan);
				checks += 2;
				assert (got == ref_conv(chan_t'(exp_chan))) else begin
					errors++;
					$display("error t=%0t o_ain%0d got %h expected %h", $time, exp_chan,
						got, ref_conv(chan_t'(exp_chan)));
				end
				assert (slave0.last_mux == exp_mux) else begin
					errors++;
					$display("error t=%0t last_mux got %h expected %h", $time,
						slave0.last_mux, exp_mux);
				end
				exp_chan = (exp_chan + 1) % 4; // wraps after channel 3
				ain_cnt++;
			end
			if (rd_valid) begin
				checks++;
				assert (rd_data == exp_rd) else begin
					errors++;
					$display("error t=%0t o_rd_data got %h expected %h", $time, rd_data, exp_rd);
				end
				assert (!nack_ok) else begin
					errors++;
					$display("read data returned after a NACKed address");
				end
				rd_cnt++;
			end
			if (nack) begin
				assert (nack_ok) else begin
					errors++;
					$display("transfer aborted on a NACK that was not expected");
				end
				nack_cnt++;
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= LIMIT) begin
			$display("timeout, run exceeded %0d cycles", LIMIT);
			$display("Some tests failed");
			$finish;
		end
	end

	task automatic host_req(input cpu_op_e op, input logic [7:0] cmd, input logic [7:0] wdata);
		@(posedge clk);
		#1;
		cpu_valid = 1'b1;
		cpu_op    = op;
		cpu_cmd   = cmd;
		cpu_wdata = wdata;
		do @(posedge clk); while (!cpu_ready); // held until accepted
		stop_mark = slave0.stop_cnt;
		#1;
		cpu_valid = 1'b0;
	endtask

	task automatic check_log(input logic [7:0] a, input logic [7:0] b, input logic [7:0] c);
		int n;
		n = slave0.wlog.size();
		checks++;
		assert (n >= 3 && slave0.wlog[n-3] == a && slave0.wlog[n-2] == b
			&& slave0.wlog[n-1] == c) else begin
			errors++;
			$display("error t=%0t wlog got %h %h %h expected %h %h %h", $time,
				slave0.wlog[n-3], slave0.wlog[n-2], slave0.wlog[n-1], a, b, c);
		end
	endtask

	initial begin
		seed = 32'hb45f_b965;
		for (int i = 0; i < 4; i++) begin
			conv_tab[i] = $random(seed);
			slave0.conv_tab[i] = conv_tab[i];
		end
		rst_n = 1'b0;
		dev_addr = 7'h40;
		cpu_valid = 1'b0;
		cpu_op = CPU_WREG;
		cpu_cmd = 8'h00;
		cpu_wdata = 8'h00;
		scan_en = 1'b0;
		silent = 1'b0;
		repeat (8) @(posedge clk);
		#1 rst_n = 1'b1;
		checks++;
		assert (!cpu_ready && !rd_valid && !ain_valid && !nack && ain0 == 0 && ain1 == 0
			&& ain2 == 0 && ain3 == 0 && scl === 1'b1 && sda === 1'b1) else begin
			errors++;
			$display("outputs or bus lines not idle after reset");
		end

		host_req(CPU_WREG, 8'h44, 8'ha5);
		while (slave0.stop_cnt == stop_mark) @(posedge clk);
		check_log(8'h80, 8'h44, 8'ha5);

		exp_rd = slave0.regs[8'h24];
		host_req(CPU_RREG, 8'h24, 8'h00);
		while (rd_cnt < 1) @(posedge clk);
		check_log(8'h80, 8'h24, 8'h81); // command then read address

		#1;
		scan_en = 1'b1;
		while (ain_cnt < 5) @(posedge clk);

		// host read in the middle of scanning
		exp_rd = slave0.regs[8'h28];
		host_req(CPU_RREG, 8'h28, 8'h00);
		while (rd_cnt < 2) @(posedge clk);
		while (ain_cnt < 7) @(posedge clk);

		#1;
		wait_mark = cycles;
		silent = 1'b1;
		while (ain_cnt < 8) @(posedge clk);
		#1;
		checks++;
		assert (cycles - wait_mark >= SCAN_BITS * 8 + `ADS_DRDY_TIMEOUT) else begin
			errors++;
			$display("scan step with DRDY held high ended before the DRDY timeout");
		end
		silent = 1'b0;

		// park the scan, then address NACK
		scan_en = 1'b0;
		host_req(CPU_WREG, 8'h44, 8'h5a);
		while (slave0.stop_cnt == stop_mark) @(posedge clk);
		check_log(8'h80, 8'h44, 8'h5a);
		#1;
		dev_addr = 7'h41;
		nack_ok = 1'b1;
		host_req(CPU_RREG, 8'h24, 8'h00);
		while (nack_cnt < 1) @(posedge clk);
		checks++;
		assert (scl === 1'b1 && sda === 1'b1) else begin
			errors++;
			$display("bus lines not released after the NACK abort");
		end
		#1;
		dev_addr = 7'h40;
		nack_ok = 1'b0;
		exp_rd = slave0.regs[8'h30];
		host_req(CPU_RREG, 8'h30, 8'h00);
		while (rd_cnt < 3) @(posedge clk);

		$display("checks=%0d errors=%0d", checks, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule
